//--- src/video_cfg.svh
`ifndef VIDEO_CFG_SVH
`define VIDEO_CFG_SVH

// chip variant codes, bit 0 set means a PAL part
`define CHIP6567R8           2'd0
`define CHIP6569R5           2'd1
`define CHIP6567R56A         2'd2
`define CHIP6569R1           2'd3

// NTSC line timing, one raster position is about 122 ns
`define NTSC_HSYNC_START     10'd409
`define NTSC_HSYNC_END       10'd446
`define NTSC_HVISIBLE_START  10'd497
`define NTSC_BURST_START     10'd451
`define NTSC_VBLANK_START    9'd14
`define NTSC_VBLANK_END      9'd22
`define NTSC_HALF_LINE       10'd260

// PAL line timing, one raster position is about 127 ns
`define PAL_HSYNC_START      10'd408
`define PAL_HSYNC_END        10'd444
`define PAL_HVISIBLE_START   10'd492
`define PAL_BURST_START      10'd449
`define PAL_VBLANK_START     9'd301
`define PAL_VBLANK_END       9'd309
`define PAL_HALF_LINE        10'd252

// vertical interval pulse shapes, in raster positions per half line
`define EQ_WIDTH             10'd18
`define SE_GAP               10'd37

// serration lines inside the nine-line vertical interval
`define SE_LINE_FIRST        4'd3
`define SE_LINE_LAST         4'd5
`define VSYNC_LINES          4'd9

// nine carrier periods of sixteen samples each
`define BURST_SAMPLES        8'd144

// burst carrier phase, 256 is a full turn
`define NTSC_BURST_PHASE     8'd128
`define PAL_BURST_PHASE_ODD  8'd160
`define PAL_BURST_PHASE_EVEN 8'd96

// default analog levels, blanking sits near 1.29 V
`define DEFAULT_BLANKING     6'd18
`define DEFAULT_BURST_AMP    3'd2

// amplitude page with a flat table, gives no chroma
`define NO_AMP               3'd7

// chroma midpoint, top six bits of the table zero of 256
`define CHROMA_ZERO          6'd32

// peak sine amplitude of page 0
`define SINE_PEAK            120

// 1 turns on the four-sample luma smoothing
`define LUMA_AVERAGE         1

`endif

//--- src/video_pkg.sv
package video_pkg;

    // horizontal position within a line
    typedef logic [9:0] raster_x_t;

    // line number
    typedef logic [8:0] raster_y_t;

    // chip variant, bit 0 selects PAL
    typedef logic [1:0] chip_sel_t;

    // luma, chroma and blanking levels
    typedef logic [5:0] level_t;

    // carrier phase, 256 steps per turn
    typedef logic [7:0] phase_t;

    // sine table amplitude page
    typedef logic [2:0] amp_t;

    // amplitude page on top, phase below
    typedef logic [10:0] rom_addr_t;

    // sine sample centred on 256
    typedef logic [8:0] sine_t;

    // colour burst sequencing
    typedef enum logic [1:0] {
        IDLE,
        ARMED,
        BURST
    } burst_state_t;

endpackage

//--- src/sync_timing.sv
`timescale 1ns/1ns
`include "video_cfg.svh"

module sync_timing import video_pkg::*;
(
    input  logic       clk_col16x,
    input  logic       rst,
    input  chip_sel_t  chip,
    input  raster_x_t  raster_x,
    input  raster_y_t  raster_y,
    output logic       hsync,
    output logic       native_active,
    output logic       vsync_valid,
    output logic [3:0] vsync_line,
    output raster_x_t  burst_start,
    output logic       line_odd,
    output raster_y_t  raster_y_q,
    output raster_x_t  raster_x_q
);

    raster_x_t hsync_start;
    raster_x_t hsync_end;
    raster_x_t hvisible_start;
    raster_x_t burst_pos;
    raster_y_t vblank_start;
    raster_y_t vblank_end;
    raster_y_t line_offset;

    // the two NTSC parts and the two PAL parts share their timing
    always_comb
    begin
        case (chip)
            `CHIP6569R1, `CHIP6569R5:
            begin
                hsync_start    = `PAL_HSYNC_START;
                hsync_end      = `PAL_HSYNC_END;
                hvisible_start = `PAL_HVISIBLE_START;
                burst_pos      = `PAL_BURST_START;
                vblank_start   = `PAL_VBLANK_START;
                vblank_end     = `PAL_VBLANK_END;
            end
            default:
            begin
                hsync_start    = `NTSC_HSYNC_START;
                hsync_end      = `NTSC_HSYNC_END;
                hvisible_start = `NTSC_HVISIBLE_START;
                burst_pos      = `NTSC_BURST_START;
                vblank_start   = `NTSC_VBLANK_START;
                vblank_end     = `NTSC_VBLANK_END;
            end
        endcase
        line_offset = raster_y - vblank_start;
    end

    // flags, raster snapshot and constants all move in the same cycle
    always_ff @(posedge clk_col16x)
    begin
        if (rst)
        begin
            hsync         <= 1'b0;
            native_active <= 1'b0;
            vsync_valid   <= 1'b0;
        end
        else
        begin
            hsync         <= (raster_x >= hsync_start) && (raster_x < hsync_end);
            native_active <= ((raster_x < hsync_start) || (raster_x >= hvisible_start)) &&
                             ((raster_y < vblank_start) || (raster_y > vblank_end));
            vsync_valid   <= (raster_y >= vblank_start) && (raster_y <= vblank_end);
        end
    end

    // payload snapshot, sampled every cycle
    always_ff @(posedge clk_col16x)
    begin
        vsync_line  <= line_offset[3:0];
        burst_start <= burst_pos;
        line_odd    <= raster_y[0];
        raster_y_q  <= raster_y;
        raster_x_q  <= raster_x;
    end

    // the line index feeds the EQ/SE selection downstream
    a_vsync_line_range : assert property (
        @(posedge clk_col16x) disable iff (rst)
        vsync_valid |-> (vsync_line < `VSYNC_LINES)
    );

endmodule

//--- src/sync_pulse_gen.sv
`timescale 1ns/1ns
`include "video_cfg.svh"

module sync_pulse_gen import video_pkg::*;
(
    input  logic      clk_col16x,
    input  logic      rst,
    input  chip_sel_t chip,
    input  raster_x_t raster_x,
    output logic      eq,
    output logic      se
);

    raster_x_t half_len;
    raster_x_t pos_ntsc;
    raster_x_t pos_pal;
    raster_x_t half_pos;
    logic      eq_next;
    logic      se_next;

    always_comb
    begin
        // position within the current half line
        pos_ntsc = raster_x % `NTSC_HALF_LINE;
        pos_pal  = raster_x % `PAL_HALF_LINE;
        half_len = chip[0] ? `PAL_HALF_LINE : `NTSC_HALF_LINE;
        half_pos = chip[0] ? pos_pal : pos_ntsc;

        // short equalization pulse at the start of each half line
        eq_next = half_pos < `EQ_WIDTH;

        // broad serration pulse, low only for the last SE_GAP positions
        se_next = half_pos < (half_len - `SE_GAP);
    end

    // one register so the pulses line up with sync_timing
    always_ff @(posedge clk_col16x)
    begin
        if (rst)
        begin
            eq <= 1'b0;
            se <= 1'b0;
        end
        else
        begin
            eq <= eq_next;
            se <= se_next;
        end
    end

endmodule

//--- src/luma_gen.sv
`timescale 1ns/1ns
`include "video_cfg.svh"

module luma_gen import video_pkg::*;
#(
    parameter int AVERAGE = 0
)
(
    input  logic       clk_col16x,
    input  logic       rst,
    input  logic       hsync,
    input  logic       native_active,
    input  logic       vsync_valid,
    input  logic [3:0] vsync_line,
    input  logic       eq,
    input  logic       se,
    input  level_t     luma_level,
    input  level_t     blanking_level,
    output logic       csync,
    output level_t     luma
);

    level_t     luma_level_q;
    level_t     blanking_level_q;
    level_t     level_next;
    level_t     hist_1;
    level_t     hist_2;
    level_t     hist_3;
    logic       se_line;
    logic       pulse;
    logic [7:0] level_sum;

    // levels arrive with the raster position, align them to the timing stage
    always_ff @(posedge clk_col16x)
    begin
        luma_level_q     <= luma_level;
        blanking_level_q <= blanking_level;
    end

    always_comb
    begin
        // EQ on lines 0-2 and 6-8, SE on lines 3-5
        se_line = (vsync_line >= `SE_LINE_FIRST) && (vsync_line <= `SE_LINE_LAST);
        pulse   = se_line ? se : eq;

        if (vsync_valid)
            level_next = pulse ? 6'd0 : blanking_level_q;
        else if (hsync)
            level_next = 6'd0;
        else if (!native_active)
            level_next = blanking_level_q;
        else
            level_next = luma_level_q;

        // current sample plus three previous ones, divided by four below
        level_sum = {2'b00, level_next} + {2'b00, hist_1} + {2'b00, hist_2} + {2'b00, hist_3};
    end

    always_ff @(posedge clk_col16x)
    begin
        if (rst)
        begin
            csync  <= 1'b0;
            luma   <= 6'd0;
            hist_1 <= 6'd0;
            hist_2 <= 6'd0;
            hist_3 <= 6'd0;
        end
        else
        begin
            csync <= vsync_valid ? ~pulse : ~hsync;
            // pulse lines pass straight through, smoothing only elsewhere
            if ((AVERAGE != 0) && !vsync_valid)
                luma <= level_sum[7:2];
            else
                luma <= level_next;
            // history shifts on every line, pulse lines included
            hist_1 <= level_next;
            hist_2 <= hist_1;
            hist_3 <= hist_2;
        end
    end

endmodule

//--- src/chroma_gen.sv
`timescale 1ns/1ns
`include "video_cfg.svh"

module chroma_gen import video_pkg::*;
(
    input  logic      clk_col16x,
    input  logic      rst,
    input  chip_sel_t chip,
    input  logic      native_active,
    input  logic      vsync_valid,
    input  raster_x_t raster_x_q,
    input  raster_y_t raster_y_q,
    input  raster_x_t burst_start,
    input  logic      line_odd,
    input  phase_t    phase,
    input  amp_t      amplitude,
    input  amp_t      burst_amplitude,
    output rom_addr_t rom_addr,
    output level_t    chroma,
    input  sine_t     rom_data
);

    logic [3:0]   phase_cnt;
    phase_t       phase_d1;
    phase_t       phase_d2;
    amp_t         amp_d1;
    amp_t         amp_d2;
    amp_t         burst_amp_d1;
    amp_t         burst_amp_d2;
    logic         active_d;
    logic         vsync_d;
    logic         odd_d;
    raster_y_t    prev_y;
    burst_state_t state;
    logic [7:0]   burst_cnt;
    phase_t       offset;
    phase_t       wave_addr;
    amp_t         page;
    amp_t         page_a;
    amp_t         page_b;

    // attributes come in with the raster, the timing flags one cycle later;
    // both meet the burst state here, two cycles after the raster input
    always_ff @(posedge clk_col16x)
    begin
        phase_d1     <= phase;
        phase_d2     <= phase_d1;
        amp_d1       <= amplitude;
        amp_d2       <= amp_d1;
        burst_amp_d1 <= burst_amplitude;
        burst_amp_d2 <= burst_amp_d1;
        odd_d        <= line_odd;
        prev_y       <= raster_y_q;
    end

    // 16 samples per carrier period, burst armed by a line change
    always_ff @(posedge clk_col16x)
    begin
        if (rst)
        begin
            phase_cnt <= 4'd0;
            state     <= IDLE;
            burst_cnt <= 8'd0;
            active_d  <= 1'b0;
            vsync_d   <= 1'b0;
        end
        else
        begin
            phase_cnt <= phase_cnt + 4'd1;
            active_d  <= native_active;
            vsync_d   <= vsync_valid;
            case (state)
                IDLE:
                    if (raster_y_q != prev_y)
                        state <= ARMED;
                ARMED:
                    if (raster_x_q >= burst_start)
                        state <= BURST;
                BURST:
                    if (burst_cnt == `BURST_SAMPLES - 8'd1)
                    begin
                        state     <= IDLE;
                        burst_cnt <= 8'd0;
                    end
                    else
                        burst_cnt <= burst_cnt + 8'd1;
                default:
                    state <= IDLE;
            endcase
        end
    end

    always_comb
    begin
        // PAL flips the picture phase on even lines, burst swings 135/225 deg
        if (active_d)
            offset = (chip[0] && !odd_d) ? 8'd0 - phase_d2 : phase_d2;
        else if (!chip[0])
            offset = `NTSC_BURST_PHASE;
        else
            offset = odd_d ? `PAL_BURST_PHASE_ODD : `PAL_BURST_PHASE_EVEN;
        wave_addr = {phase_cnt, 4'b0000} + offset;

        if (vsync_d)
            page = `NO_AMP;
        else if (active_d)
            page = amp_d2;
        else if (state == BURST)
            page = burst_amp_d2;
        else
            page = `NO_AMP;
    end

    // stage A then table read, page delayed to meet the read data
    always_ff @(posedge clk_col16x)
    begin
        rom_addr <= {page, wave_addr};
        if (rst)
        begin
            page_a <= `NO_AMP;
            page_b <= `NO_AMP;
            chroma <= `CHROMA_ZERO;
        end
        else
        begin
            page_a <= page;
            page_b <= page_a;
            chroma <= (page_b == `NO_AMP) ? `CHROMA_ZERO : rom_data[8:3];
        end
    end

    a_count_in_burst : assert property (
        @(posedge clk_col16x) disable iff (rst)
        (burst_cnt != 8'd0) |-> (state == BURST)
    );

    a_count_bound : assert property (
        @(posedge clk_col16x) disable iff (rst)
        burst_cnt <= `BURST_SAMPLES
    );

endmodule

//--- src/sine_rom.sv
`timescale 1ns/1ns
`include "video_cfg.svh"

module sine_rom import video_pkg::*;
(
    input  logic      clk_col16x,
    input  rom_addr_t addr,
    output sine_t     data
);

    localparam real PI = 3.14159265358979;

    sine_t sine_mem [0:2047];

    // eight pages of 256 phase steps, the peak shrinks by a seventh per page
    initial
    begin
        int  peak;
        real angle;
        for (int pg = 0; pg < 8; pg++)
        begin
            // page 7 has zero peak, so the table sits flat at 256
            peak = (`SINE_PEAK * (int'(`NO_AMP) - pg)) / int'(`NO_AMP);
            for (int ph = 0; ph < 256; ph++)
            begin
                angle = 2.0 * PI * ph / 256.0;
                sine_mem[pg * 256 + ph] = sine_t'(256 + int'(peak * $sin(angle)));
            end
        end
    end

    // registered read
    always_ff @(posedge clk_col16x)
    begin
        data <= sine_mem[addr];
    end

endmodule

//--- src/comp_video_top.sv
`timescale 1ns/1ns
`include "video_cfg.svh"

module comp_video_top import video_pkg::*;
(
    input  logic      clk_col16x,
    input  logic      rst,
    input  chip_sel_t chip,
    input  raster_x_t raster_x,
    input  raster_y_t raster_y,
    input  level_t    luma_level,
    input  phase_t    phase,
    input  amp_t      amplitude,
    input  level_t    blanking_level,
    input  amp_t      burst_amplitude,
    output logic      csync,
    output level_t    luma,
    output level_t    chroma,
    output logic      native_active
);

    logic       hsync;
    logic       vsync_valid;
    logic [3:0] vsync_line;
    raster_x_t  burst_start;
    logic       line_odd;
    raster_y_t  raster_y_q;
    raster_x_t  raster_x_q;
    logic       eq;
    logic       se;
    rom_addr_t  rom_addr;
    sine_t      rom_data;

    // line timing snapshot shared by luma and chroma
    sync_timing u_sync_timing (
        .clk_col16x    (clk_col16x),
        .rst           (rst),
        .chip          (chip),
        .raster_x      (raster_x),
        .raster_y      (raster_y),
        .hsync         (hsync),
        .native_active (native_active),
        .vsync_valid   (vsync_valid),
        .vsync_line    (vsync_line),
        .burst_start   (burst_start),
        .line_odd      (line_odd),
        .raster_y_q    (raster_y_q),
        .raster_x_q    (raster_x_q)
    );

    sync_pulse_gen u_sync_pulse_gen (
        .clk_col16x (clk_col16x),
        .rst        (rst),
        .chip       (chip),
        .raster_x   (raster_x),
        .eq         (eq),
        .se         (se)
    );

    luma_gen #(
        .AVERAGE (`LUMA_AVERAGE)
    ) u_luma_gen (
        .clk_col16x     (clk_col16x),
        .rst            (rst),
        .hsync          (hsync),
        .native_active  (native_active),
        .vsync_valid    (vsync_valid),
        .vsync_line     (vsync_line),
        .eq             (eq),
        .se             (se),
        .luma_level     (luma_level),
        .blanking_level (blanking_level),
        .csync          (csync),
        .luma           (luma)
    );

    chroma_gen u_chroma_gen (
        .clk_col16x      (clk_col16x),
        .rst             (rst),
        .chip            (chip),
        .native_active   (native_active),
        .vsync_valid     (vsync_valid),
        .raster_x_q      (raster_x_q),
        .raster_y_q      (raster_y_q),
        .burst_start     (burst_start),
        .line_odd        (line_odd),
        .phase           (phase),
        .amplitude       (amplitude),
        .burst_amplitude (burst_amplitude),
        .rom_addr        (rom_addr),
        .chroma          (chroma),
        .rom_data        (rom_data)
    );

    sine_rom u_sine_rom (
        .clk_col16x (clk_col16x),
        .addr       (rom_addr),
        .data       (rom_data)
    );

endmodule

//--- dv/tb_clock_gen.sv
`timescale 1ns/1ns

module tb_clock_gen
#(
    parameter int PERIOD_NS    = 20,
    parameter int RESET_CYCLES = 2
)
(
    output logic clk_col16x,
    output logic rst
);

    // free running colour clock
    initial
    begin
        clk_col16x = 1'b0;
        forever #(PERIOD_NS / 2) clk_col16x = ~clk_col16x;
    end

    // reset released just after an edge, like every other input
    initial
    begin
        rst = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk_col16x);
        #2;
        rst = 1'b0;
    end

endmodule

//--- dv/comp_video_checker.sv
`timescale 1ns/1ns

module comp_video_checker import video_pkg::*;
(
    input logic   clk_col16x,
    input logic   check_en,
    input logic   csync,
    input level_t luma,
    input level_t chroma,
    input logic   native_active,
    input logic   exp_csync,
    input level_t exp_luma,
    input level_t exp_chroma,
    input logic   exp_native
);

    int    error_count = 0;
    int    check_count = 0;
    int    test_count  = 0;
    int    test_checks = 0;
    int    test_errors = 0;
    string test_name   = "none";

    task automatic compare_value(input string name, input logic [7:0] actual,
                                 input logic [7:0] expected);
        test_checks++;
        check_count++;
        // X or Z on an output counts as a wrong value
        if (actual !== expected)
        begin
            test_errors++;
            error_count++;
            $display("mismatch at %0t ns: %s expected %0d, actual %0d",
                     $time, name, expected, actual);
        end
    endtask

    task automatic start_test(input string name);
        test_name   = name;
        test_checks = 0;
        test_errors = 0;
    endtask

    task automatic finish_test();
        test_count++;
        $display("test %s: %0d checks, %0d errors", test_name, test_checks, test_errors);
    endtask

    task automatic report_totals();
        $display("summary: %0d tests, %0d checks, %0d errors",
                 test_count, check_count, error_count);
    endtask

    // outputs move on the rising edge, so mid-cycle they are settled
    always @(negedge clk_col16x)
    begin
        if (check_en)
        begin
            compare_value("csync", {7'd0, csync}, {7'd0, exp_csync});
            compare_value("luma", {2'd0, luma}, {2'd0, exp_luma});
            compare_value("chroma", {2'd0, chroma}, {2'd0, exp_chroma});
            compare_value("native_active", {7'd0, native_active}, {7'd0, exp_native});
        end
    end

endmodule

//--- dv/comp_video_tb.sv
`timescale 1ns/1ns
`include "video_cfg.svh"

module comp_video_tb import video_pkg::*;
();

    localparam int RAND_SEED      = 44086;
    localparam int LINES_PER_TEST = 16;
    // four chip scans plus the reset window counted as one line
    localparam int TOTAL_LINES    = 4 * LINES_PER_TEST + 1;
    localparam int WATCHDOG_NS    = TOTAL_LINES * 520 * 20 * 2;
    localparam int SETTLE_STEPS   = 6;

    logic      clk_col16x;
    logic      rst;
    chip_sel_t chip;
    raster_x_t raster_x;
    raster_y_t raster_y;
    level_t    luma_level;
    phase_t    phase;
    amp_t      amplitude;
    level_t    blanking_level;
    amp_t      burst_amplitude;
    logic      csync;
    level_t    luma;
    level_t    chroma;
    logic      native_active;

    // expected outputs for the current cycle
    logic      check_en = 1'b0;
    logic      exp_csync;
    level_t    exp_luma;
    level_t    exp_chroma;
    logic      exp_native;

    // reference model state
    level_t       sine_top [0:2047];
    level_t       luma_hist [0:2];
    logic         active_q;
    logic         csync_pipe [0:1];
    level_t       luma_pipe [0:1];
    level_t       chroma_pipe [0:4];
    burst_state_t ref_state;
    int           ref_burst_n;
    raster_y_t    ref_prev_y;
    logic [3:0]   ref_cnt;

    tb_clock_gen #(
        .PERIOD_NS    (20),
        .RESET_CYCLES (2)
    ) u_tb_clock_gen (
        .clk_col16x (clk_col16x),
        .rst        (rst)
    );

    comp_video_top u_comp_video_top (
        .clk_col16x      (clk_col16x),
        .rst             (rst),
        .chip            (chip),
        .raster_x        (raster_x),
        .raster_y        (raster_y),
        .luma_level      (luma_level),
        .phase           (phase),
        .amplitude       (amplitude),
        .blanking_level  (blanking_level),
        .burst_amplitude (burst_amplitude),
        .csync           (csync),
        .luma            (luma),
        .chroma          (chroma),
        .native_active   (native_active)
    );

    comp_video_checker u_checker (
        .clk_col16x    (clk_col16x),
        .check_en      (check_en),
        .csync         (csync),
        .luma          (luma),
        .chroma        (chroma),
        .native_active (native_active),
        .exp_csync     (exp_csync),
        .exp_luma      (exp_luma),
        .exp_chroma    (exp_chroma),
        .exp_native    (exp_native)
    );

    // 256 + round(A * sin), A shrinking by sevenths, top six bits kept
    task automatic build_sine_model();
        int  peak;
        int  step;
        real v;
        for (int pg = 0; pg < 8; pg++)
        begin
            peak = (`SINE_PEAK * (7 - pg)) / 7;
            for (int ph = 0; ph < 256; ph++)
            begin
                v = peak * $sin(2.0 * 3.141592653589793 * ph / 256.0);
                if (v >= 0.0)
                    step = $rtoi(v + 0.5);
                else
                    step = -$rtoi(0.5 - v);
                sine_top[pg * 256 + ph] = level_t'((256 + step) >> 3);
            end
        end
    endtask

    // four-sample floor mean outside the pulse lines
    task automatic smooth_luma(input level_t lvl, input logic pulse_line, output level_t result);
        int sum;
        sum = lvl + luma_hist[0] + luma_hist[1] + luma_hist[2];
        if ((`LUMA_AVERAGE != 0) && !pulse_line)
            result = level_t'(sum / 4);
        else
            result = lvl;
        luma_hist[2] = luma_hist[1];
        luma_hist[1] = luma_hist[0];
        luma_hist[0] = lvl;
    endtask

    task automatic prime_reference();
        level_t first_lvl;
        for (int i = 0; i < 3; i++)
            luma_hist[i] = 6'd0;
        for (int i = 0; i < 5; i++)
            chroma_pipe[i] = `CHROMA_ZERO;
        ref_state   = IDLE;
        ref_burst_n = 0;
        ref_prev_y  = raster_y;
        // a position meets the carrier counter two edges after it is sampled
        ref_cnt     = 4'd2;
        active_q    = 1'b0;
        csync_pipe[1] = 1'b0;
        luma_pipe[1]  = 6'd0;
        // timing stage leaves reset with no sync and blanked
        csync_pipe[0] = 1'b1;
        smooth_luma(blanking_level, 1'b0, first_lvl);
        luma_pipe[0]  = first_lvl;
        exp_csync  = 1'b0;
        exp_luma   = 6'd0;
        exp_chroma = `CHROMA_ZERO;
        exp_native = 1'b0;
    endtask

    // expected outputs of the position now on the inputs
    task automatic model_position();
        raster_x_t hs, he, hvis, bstart, half;
        raster_y_t vbs, vbe;
        logic      is_pal, in_hsync, in_vsync, active, pulse, csync_exp;
        int        line_idx, half_pos, offset, page, addr;
        level_t    lvl, luma_exp, chroma_exp;

        is_pal = chip[0];
        hs     = is_pal ? `PAL_HSYNC_START : `NTSC_HSYNC_START;
        he     = is_pal ? `PAL_HSYNC_END : `NTSC_HSYNC_END;
        hvis   = is_pal ? `PAL_HVISIBLE_START : `NTSC_HVISIBLE_START;
        bstart = is_pal ? `PAL_BURST_START : `NTSC_BURST_START;
        half   = is_pal ? `PAL_HALF_LINE : `NTSC_HALF_LINE;
        vbs    = is_pal ? `PAL_VBLANK_START : `NTSC_VBLANK_START;
        vbe    = is_pal ? `PAL_VBLANK_END : `NTSC_VBLANK_END;

        in_hsync = (raster_x >= hs) && (raster_x < he);
        in_vsync = (raster_y >= vbs) && (raster_y <= vbe);
        active   = ((raster_x < hs) || (raster_x >= hvis)) && !in_vsync;
        line_idx = raster_y - vbs;
        half_pos = raster_x % half;
        // serration on the middle three lines of the nine
        if ((line_idx >= 3) && (line_idx <= 5))
            pulse = half_pos < (half - `SE_GAP);
        else
            pulse = half_pos < `EQ_WIDTH;

        if (in_vsync)
        begin
            csync_exp = !pulse;
            lvl       = pulse ? 6'd0 : blanking_level;
        end
        else
        begin
            csync_exp = !in_hsync;
            if (in_hsync)
                lvl = 6'd0;
            else if (!active)
                lvl = blanking_level;
            else
                lvl = luma_level;
        end
        smooth_luma(lvl, in_vsync, luma_exp);

        // burst armed by a line change, runs BURST_SAMPLES positions
        case (ref_state)
            IDLE:
                if (raster_y != ref_prev_y)
                    ref_state = ARMED;
            ARMED:
                if (raster_x >= bstart)
                begin
                    ref_state   = BURST;
                    ref_burst_n = 1;
                end
            default:
                if (ref_burst_n == `BURST_SAMPLES)
                begin
                    ref_state   = IDLE;
                    ref_burst_n = 0;
                end
                else
                    ref_burst_n++;
        endcase
        ref_prev_y = raster_y;

        if (active)
            offset = (is_pal && !raster_y[0]) ? (256 - phase) % 256 : phase;
        else if (!is_pal)
            offset = `NTSC_BURST_PHASE;
        else
            offset = raster_y[0] ? `PAL_BURST_PHASE_ODD : `PAL_BURST_PHASE_EVEN;
        addr = (ref_cnt * 16 + offset) % 256;
        ref_cnt = ref_cnt + 4'd1;

        if (in_vsync)
            page = 7;
        else if (active)
            page = amplitude;
        else if (ref_state == BURST)
            page = burst_amplitude;
        else
            page = 7;
        chroma_exp = (page == 7) ? `CHROMA_ZERO : sine_top[page * 256 + addr];

        // 1, 2 and 5 cycle latencies
        exp_native    = active_q;
        active_q      = active;
        exp_csync     = csync_pipe[1];
        exp_luma      = luma_pipe[1];
        csync_pipe[1] = csync_pipe[0];
        luma_pipe[1]  = luma_pipe[0];
        csync_pipe[0] = csync_exp;
        luma_pipe[0]  = luma_exp;
        exp_chroma    = chroma_pipe[4];
        for (int i = 4; i > 0; i--)
            chroma_pipe[i] = chroma_pipe[i - 1];
        chroma_pipe[0] = chroma_exp;
    endtask

    task automatic drive_position(input raster_x_t x, input raster_y_t y);
        raster_x   = x;
        raster_y   = y;
        luma_level = level_t'($urandom % 64);
        phase      = phase_t'($urandom % 256);
        amplitude  = amp_t'($urandom % 8);
        model_position();
        @(posedge clk_col16x);
        #2;
    endtask

    task automatic run_chip_scan(input chip_sel_t chip_code, input string name);
        int        line_len;
        int        settle;
        int        step;
        raster_y_t vbs;
        raster_y_t y;
        // chroma offset follows chip ahead of the pipeline, let a change drain
        settle   = (chip_code != chip) ? SETTLE_STEPS : 0;
        line_len = chip_code[0] ? 2 * `PAL_HALF_LINE : 2 * `NTSC_HALF_LINE;
        vbs      = chip_code[0] ? `PAL_VBLANK_START : `NTSC_VBLANK_START;
        y        = vbs - 9'd3;
        step     = 0;
        u_checker.start_test(name);
        chip = chip_code;
        for (int line = 0; line < LINES_PER_TEST; line++)
        begin
            // next line, or now and then a jump into the vertical interval
            if (line > 0)
            begin
                if ($urandom % 6 == 0)
                    y = vbs + raster_y_t'($urandom % 9);
                else
                    y = y + 9'd1;
            end
            blanking_level  = level_t'($urandom % 64);
            burst_amplitude = amp_t'($urandom % 7);
            for (int x = 0; x < line_len; x++)
            begin
                check_en = (step >= settle);
                drive_position(raster_x_t'(x), y);
                step++;
            end
        end
        u_checker.finish_test();
    endtask

    initial
    begin
        int seed_val;
        seed_val        = $urandom(RAND_SEED);
        chip            = `CHIP6567R8;
        raster_x        = 10'd0;
        raster_y        = 9'd0;
        luma_level      = 6'd0;
        phase           = 8'd0;
        amplitude       = `NO_AMP;
        blanking_level  = `DEFAULT_BLANKING;
        burst_amplitude = `DEFAULT_BURST_AMP;
        build_sine_model();
        prime_reference();

        // outputs sit at their reset values while rst is high
        u_checker.start_test("reset");
        @(posedge clk_col16x);
        #2;
        check_en = 1'b1;
        @(negedge rst);
        u_checker.finish_test();

        run_chip_scan(`CHIP6567R8, "chip_6567r8");
        run_chip_scan(`CHIP6567R56A, "chip_6567r56a");
        run_chip_scan(`CHIP6569R1, "chip_6569r1");
        run_chip_scan(`CHIP6569R5, "chip_6569r5");
        check_en = 1'b0;

        u_checker.report_totals();
        if (u_checker.error_count == 0)
            $display("ALL CHECKS PASSED");
        else
            $display("CHECKS FAILED");
        $finish;
    end

    // watchdog, twice the time of all scanned lines at the longest line
    initial
    begin
        #(WATCHDOG_NS);
        $display("timeout: the scan did not complete within %0d ns", WATCHDOG_NS);
        $display("CHECKS FAILED");
        $finish;
    end

endmodule

//--- flist.f
+incdir+src
src/video_pkg.sv
src/sync_timing.sv
src/sync_pulse_gen.sv
src/luma_gen.sv
src/chroma_gen.sv
src/sine_rom.sv
src/comp_video_top.sv
dv/tb_clock_gen.sv
dv/comp_video_checker.sv
dv/comp_video_tb.sv

//--- Bender.yml
package:
  name: comp_video

export_include_dirs:
  - src

sources:
  - files:
      - src/video_pkg.sv
      - src/sync_timing.sv
      - src/sync_pulse_gen.sv
      - src/luma_gen.sv
      - src/chroma_gen.sv
      - src/sine_rom.sv
      - src/comp_video_top.sv

  - target: test
    include_dirs:
      - src
    files:
      - dv/tb_clock_gen.sv
      - dv/comp_video_checker.sv
      - dv/comp_video_tb.sv
